// ==== source/timer_ssd_pkg.sv ====
package timer_ssd_pkg;

    // Frame buffer and credit loop
    localparam int BUF_DEPTH = 4;
    localparam int CREDIT_W = 3;                        // Holds 0 to BUF_DEPTH
    localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

    // SPI timing
    localparam int SCK_HALF = 4;                        // System clocks per sck half period
    localparam int SCK_CNT_W = $clog2(2 * SCK_HALF);
    localparam int GAP_HALVES = 16;                     // Idle fall enables after each byte
    localparam int SPI_CNT_W = $clog2(GAP_HALVES + 1);

    // Display commands
    localparam logic [7:0] CMD_RESET = 8'h76;
    localparam logic [7:0] CMD_CLEAR = 8'h77;
    localparam logic [7:0] CMD_CLEAR_ARG = 8'h10;
    localparam logic [7:0] CMD_DIG2 = 8'h7C;            // Minutes position
    localparam logic [7:0] CMD_DIG3 = 8'h7D;
    localparam logic [7:0] CMD_DIG4 = 8'h7E;

    typedef struct packed {
        logic [2:0] min;
        logic [2:0] sec_ten;                            // 0 to 5
        logic [3:0] sec_one;                            // 0 to 9
    } time_frame_t;

    // Segment a in bit 0, g in bit 6, no decimal point
    localparam logic [15:0][7:0] seg_table = {
        8'h00,                                          // 15
        8'h00,
        8'h00,
        8'h00,
        8'h00,
        8'h00,                                          // 10
        8'h6F,
        8'h7F,
        8'h07,
        8'h7D,
        8'h6D,
        8'h66,
        8'h4F,
        8'h5B,
        8'h06,
        8'h3F                                           // 0
    };

endpackage

// ==== source/time_counter.sv ====
`timescale 1ns/1ps

module time_counter (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       tick,
    input  logic                       enable,
    input  logic                       clear,
    input  logic                       credit_return,
    output logic                       push,
    output timer_ssd_pkg::time_frame_t push_frame
);
    import timer_ssd_pkg::*;

    time_frame_t         count;
    time_frame_t         nxt_count;
    logic                advance;
    logic                pending;
    logic                want_push;
    logic [CREDIT_W-1:0] credits;

    assign advance = tick && enable;

    // Decimal carry chain for m:ss
    always_comb begin
        nxt_count = count;
        if (clear) begin
            nxt_count = '0;
        end else if (advance) begin
            if (count.sec_one == 4'd9) begin
                nxt_count.sec_one = 4'd0;
                if (count.sec_ten == 3'd5) begin
                    nxt_count.sec_ten = 3'd0;
                    nxt_count.min = count.min + 3'd1;   // 7:59 wraps to 0:00
                end else begin
                    nxt_count.sec_ten = count.sec_ten + 3'd1;
                end
            end else begin
                nxt_count.sec_one = count.sec_one + 4'd1;
            end
        end
    end

    // A new count can go out in the same cycle it is made
    assign want_push = pending || advance || clear;
    assign push = want_push && (credits != '0);
    assign push_frame = nxt_count;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= '0;
            pending <= 1'b0;
            credits <= CREDIT_W'(BUF_DEPTH);
        end else begin
            count <= nxt_count;
            pending <= want_push && !push;              // Newest count stays pending
            case ({push, credit_return})
                2'b10: begin
                    credits <= credits - 1'b1;
                end
                2'b01: begin
                    credits <= credits + 1'b1;
                end
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

endmodule

// ==== source/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer #(
    parameter type payload_t = logic [9:0]
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     avail,
    output payload_t head,
    output logic     credit_return
);
    import timer_ssd_pkg::*;

    payload_t             mem [BUF_DEPTH];
    logic [BUF_PTR_W-1:0] wr_ptr;
    logic [BUF_PTR_W-1:0] rd_ptr;
    logic [CREDIT_W-1:0]  fill;
    logic                 do_pop;

    assign avail = (fill != '0);
    assign head = mem[rd_ptr];
    assign do_pop = pop && avail;
    assign credit_return = do_pop;                      // One credit per entry freed

    // Producer holds credits, so no full check here
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == BUF_PTR_W'(BUF_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == BUF_PTR_W'(BUF_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (push && !do_pop) begin
                fill <= fill + 1'b1;
            end else if (!push && do_pop) begin
                fill <= fill - 1'b1;
            end
        end
    end

endmodule

// ==== source/sck_divider.sv ====
`timescale 1ns/1ps

module sck_divider (
    input  logic clk,
    input  logic nrst,
    input  logic sck_clear,
    output logic sck_rise,
    output logic sck_fall
);
    import timer_ssd_pkg::*;

    logic [SCK_CNT_W-1:0] phase_cnt;

    // Fall phase first, rise phase SCK_HALF clocks later
    assign sck_fall = !sck_clear && (phase_cnt == '0);
    assign sck_rise = !sck_clear && (phase_cnt == SCK_CNT_W'(SCK_HALF));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            phase_cnt <= '0;
        end else if (sck_clear) begin
            phase_cnt <= '0;                            // Parked at start of fall phase
        end else if (phase_cnt == SCK_CNT_W'(2 * SCK_HALF - 1)) begin
            phase_cnt <= '0;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

endmodule

// ==== source/ssd_spi_master.sv ====
`timescale 1ns/1ps

module ssd_spi_master (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       clear,
    input  logic                       avail,
    input  timer_ssd_pkg::time_frame_t head,
    input  logic                       sck_rise,
    input  logic                       sck_fall,
    output logic                       pop,
    output logic                       sck_clear,
    output logic                       ss,
    output logic                       sck,
    output logic                       sdi
);
    import timer_ssd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SEND,
        WAIT
    } state_t;

    state_t               state;
    logic                 init_owed;
    logic                 flush;
    logic                 drop_frame;
    logic                 gap_ss;
    logic [3:0]           byte_idx;
    logic [SPI_CNT_W-1:0] cnt;
    logic [47:0]          frame_word;
    logic [71:0]          shift_word;

    assign frame_word = {
        CMD_DIG2, seg_table[{1'b0, head.min}],
        CMD_DIG3, seg_table[{1'b0, head.sec_ten}],
        CMD_DIG4, seg_table[head.sec_one]
    };

    // Frames queued before a clear are discarded up to the fresh 0:00
    assign drop_frame = flush && (head != '0);

    // Bytes 0..2 are init, 3..8 the frame; odd bytes and byte 0 keep ss low
    assign gap_ss = (byte_idx != 4'd0) && !byte_idx[0];

    assign pop = (state == LOAD) && avail && !clear;
    assign sck_clear = clear || (state == IDLE) || (state == LOAD);

    always_ff @(posedge clk) begin
        if (state == LOAD) begin
            if (init_owed) begin
                shift_word <= {CMD_RESET, CMD_CLEAR, CMD_CLEAR_ARG, frame_word};
            end else begin
                shift_word <= {frame_word, 24'd0};
            end
        end else if (state == SEND && sck_fall && cnt != SPI_CNT_W'(8)) begin
            shift_word <= {shift_word[70:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= IDLE;
            init_owed <= 1'b1;
            flush <= 1'b0;
            byte_idx <= '0;
            cnt <= '0;
            ss <= 1'b1;
            sck <= 1'b0;
            sdi <= 1'b0;
        end else if (clear) begin
            state <= IDLE;                              // Abort, resend init next time
            init_owed <= 1'b1;
            flush <= 1'b1;
            byte_idx <= '0;
            cnt <= '0;
            ss <= 1'b1;
            sck <= 1'b0;
            sdi <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (avail) begin
                        state <= LOAD;
                    end else begin
                        flush <= 1'b0;
                    end
                end
                LOAD: begin
                    if (drop_frame) begin
                        state <= IDLE;
                    end else begin
                        flush <= 1'b0;
                        init_owed <= 1'b0;
                        byte_idx <= init_owed ? 4'd0 : 4'd3;
                        cnt <= '0;
                        state <= SEND;
                    end
                end
                SEND: begin
                    ss <= 1'b0;
                    if (sck_fall) begin
                        sck <= 1'b0;
                        if (cnt == SPI_CNT_W'(8)) begin
                            cnt <= '0;
                            sdi <= 1'b0;
                            state <= WAIT;
                        end else begin
                            cnt <= cnt + 1'b1;
                            sdi <= shift_word[71];      // MSB first
                        end
                    end else if (sck_rise && cnt != '0) begin
                        sck <= 1'b1;
                    end
                end
                WAIT: begin
                    ss <= gap_ss;
                    if (sck_fall) begin
                        if (cnt == SPI_CNT_W'(GAP_HALVES - 1)) begin
                            cnt <= '0;
                            if (byte_idx == 4'd8) begin
                                state <= IDLE;
                            end else begin
                                byte_idx <= byte_idx + 1'b1;
                                state <= SEND;
                            end
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/timer_ssd_top.sv ====
`timescale 1ns/1ps

module timer_ssd_top (
    input  logic clk,
    input  logic nrst,
    input  logic tick,
    input  logic enable,
    input  logic clear,
    output logic ss,
    output logic sck,
    output logic sdi
);
    import timer_ssd_pkg::*;

    time_frame_t push_frame;
    time_frame_t head;
    logic        push;
    logic        pop;
    logic        avail;
    logic        credit_return;
    logic        sck_clear;
    logic        sck_rise;
    logic        sck_fall;

    time_counter u_counter (
        .clk           (clk),
        .nrst          (nrst),
        .tick          (tick),
        .enable        (enable),
        .clear         (clear),
        .credit_return (credit_return),
        .push          (push),
        .push_frame    (push_frame)
    );

    frame_buffer #(
        .payload_t (time_frame_t)
    ) u_buffer (
        .clk           (clk),
        .nrst          (nrst),
        .push          (push),
        .push_data     (push_frame),
        .pop           (pop),
        .avail         (avail),
        .head          (head),
        .credit_return (credit_return)
    );

    sck_divider u_divider (
        .clk       (clk),
        .nrst      (nrst),
        .sck_clear (sck_clear),
        .sck_rise  (sck_rise),
        .sck_fall  (sck_fall)
    );

    ssd_spi_master u_master (
        .clk       (clk),
        .nrst      (nrst),
        .clear     (clear),
        .avail     (avail),
        .head      (head),
        .sck_rise  (sck_rise),
        .sck_fall  (sck_fall),
        .pop       (pop),
        .sck_clear (sck_clear),
        .ss        (ss),
        .sck       (sck),
        .sdi       (sdi)
    );

endmodule

// ==== dv/timer_ssd_assertions.sv ====
`timescale 1ns/1ps

module timer_ssd_assertions (
    input logic                               clk,
    input logic                               nrst,
    input logic                               push,
    input logic [timer_ssd_pkg::CREDIT_W-1:0] fill,
    input logic                               ss,
    input logic                               sck,
    input logic                               sdi
);
    import timer_ssd_pkg::*;

    // Credit loop keeps the FIFO from overflowing
    no_overflow: assert property (@(posedge clk) disable iff (!nrst)
        push |-> (fill < CREDIT_W'(BUF_DEPTH)))
        else $error("push into a full frame buffer");

    sck_idle_low: assert property (@(posedge clk) disable iff (!nrst)
        ss |-> !sck)
        else $error("sck high while ss is high");

    sdi_stable: assert property (@(posedge clk) disable iff (!nrst)
        ($past(sck) && sck) |-> $stable(sdi))
        else $error("sdi changed while sck was high");

endmodule

bind frame_buffer timer_ssd_assertions u_buf_chk (
    .clk(clk), .nrst(nrst), .push(push), .fill(fill),
    .ss(1'b1), .sck(1'b0), .sdi(1'b0)
);

bind ssd_spi_master timer_ssd_assertions u_spi_chk (
    .clk(clk), .nrst(nrst), .push(1'b0), .fill('0),
    .ss(ss), .sck(sck), .sdi(sdi)
);

// ==== dv/timer_ssd_tb.sv ====
`timescale 1ns/1ps

module timer_ssd_tb;

    logic clk;
    logic nrst;
    logic tick;
    logic enable;
    logic clear;
    logic ss;
    logic sck;
    logic sdi;

    logic [15:0] lfsr_state = 16'd75;
    logic [7:0]  seg_ref [10] = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66,
                                  8'h6D, 8'h7D, 8'h07, 8'h7F, 8'h6F};
    logic [7:0]  init_ref [3] = '{8'h76, 8'h77, 8'h10};
    logic [7:0]  cmd_ref [3] = '{8'h7C, 8'h7D, 8'h7E};

    int error_count = 0;
    int model_val;                                      // m*100 + tens*10 + ones
    int history[$];
    int last_idx;
    int shown_val;
    bit shown_valid;
    bit expect_init;
    bit after_clear;
    int init_pos;
    int frame_pos;
    int bit_cnt;
    logic [7:0] rx_byte;
    int digits[3];

    timer_ssd_top dut (
        .clk(clk), .nrst(nrst), .tick(tick), .enable(enable), .clear(clear),
        .ss(ss), .sck(sck), .sdi(sdi)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic int rand_bits(int n);
        int r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    function automatic int step_time(int v);
        int m;
        int t;
        int o;
        m = v / 100;
        t = (v / 10) % 10;
        o = v % 10;
        o++;
        if (o == 10) begin
            o = 0;
            t++;
            if (t == 6) begin
                t = 0;
                m = (m + 1) % 8;                        // 7:59 back to 0:00
            end
        end
        return m * 100 + t * 10 + o;
    endfunction

    function automatic int decode_seg(logic [7:0] b);
        for (int i = 0; i < 10; i++) begin
            if (seg_ref[i] == b) return i;
        end
        return -1;
    endfunction

    task automatic check_shown(int v);
        int found;
        found = -1;
        for (int i = last_idx + 1; i < history.size(); i++) begin
            if (history[i] == v && found < 0) found = i;
        end
        assert (found >= 0) else begin
            error_count++;
            $display("mismatch at %0t: shown %0d not a later model count", $time, v);
        end
        if (after_clear) begin
            assert (v == 0) else begin
                error_count++;
                $display("mismatch at %0t: first frame after clear shows %0d", $time, v);
            end
            after_clear = 1'b0;
        end
        if (found >= 0) last_idx = found;
        shown_val = v;
        shown_valid = 1'b1;
    endtask

    task automatic take_byte(logic [7:0] b);
        int d;
        if (expect_init) begin
            assert (b == init_ref[init_pos]) else begin
                error_count++;
                $display("mismatch at %0t: init byte %0d is %h", $time, init_pos, b);
            end
            init_pos++;
            if (init_pos == 3) expect_init = 1'b0;
        end else if (frame_pos % 2 == 0) begin
            assert (b == cmd_ref[frame_pos / 2]) else begin
                error_count++;
                $display("mismatch at %0t: digit select %0d is %h", $time, frame_pos, b);
            end
            frame_pos++;
        end else begin
            d = decode_seg(b);
            assert (d >= 0 && !(frame_pos == 3 && d > 5) && !(frame_pos == 1 && d > 7))
                else begin
                error_count++;
                $display("mismatch at %0t: bad digit pattern %h", $time, b);
            end
            digits[frame_pos / 2] = d;
            frame_pos++;
            if (frame_pos == 6) begin
                frame_pos = 0;
                check_shown(digits[0] * 100 + digits[1] * 10 + digits[2]);
            end
        end
    endtask

    // Reference counter and clear handling
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            model_val = 0;
            history.delete();
            last_idx = -1;
            expect_init = 1'b1;
            after_clear = 1'b0;
            init_pos = 0;
            frame_pos = 0;
            bit_cnt = 0;
        end else if (clear) begin
            model_val = 0;
            history = '{0};
            last_idx = -1;
            expect_init = 1'b1;                         // Abort restarts byte stream
            after_clear = 1'b1;
            init_pos = 0;
            frame_pos = 0;
            bit_cnt = 0;
        end else if (tick && enable) begin
            model_val = step_time(model_val);
            history.push_back(model_val);
        end
    end

    always @(posedge sck) begin
        if (!ss) begin
            rx_byte = {rx_byte[6:0], sdi};
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                take_byte(rx_byte);
            end
        end
    end

    always @(posedge ss) bit_cnt = 0;

    task automatic drive(bit t, bit e, bit c);
        @(posedge clk);
        #2;
        tick = t;
        enable = e;
        clear = c;
    endtask

    task automatic wait_settle();
        int cycles;
        cycles = 0;
        while (!(shown_valid && shown_val == model_val && ss) && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= 20000) begin
            error_count++;
            $display("timeout at %0t: display never reached the final count", $time);
        end
        assert (shown_val == model_val) else begin
            error_count++;
            $display("mismatch at %0t: shown %0d, model %0d", $time, shown_val, model_val);
        end
    endtask

    initial begin
        tick = 1'b0;
        enable = 1'b0;
        clear = 1'b0;
        nrst = 1'b0;
        shown_val = 0;
        shown_valid = 1'b0;
        repeat (3) @(posedge clk);
        #2 nrst = 1'b1;
        assert (ss && !sck && !sdi) else begin
            error_count++;
            $display("mismatch at %0t: SPI lines not idle after reset", $time);
        end
        for (int i = 0; i < 3000; i++) begin
            drive(rand_bits(7) == 0, rand_bits(3) != 0, 1'b0);
        end
        drive(1'b0, 1'b1, 1'b0);
        wait_settle();
        for (int i = 0; i < 300; i++) begin                 // Ticks ignored
            drive(rand_bits(2) == 0, 1'b0, 1'b0);
            assert (ss) else begin
                error_count++;
                $display("mismatch at %0t: SPI frame started with enable low", $time);
            end
        end
        drive(1'b0, 1'b1, 1'b1);
        drive(1'b0, 1'b1, 1'b0);
        wait_settle();
        for (int i = 0; i < 1200; i++) begin                // Dense ticks wrap past 7:59
            drive(rand_bits(1) == 1, 1'b1, 1'b0);
        end
        drive(1'b0, 1'b1, 1'b0);
        wait_settle();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== timer_ssd.f ====
source/timer_ssd_pkg.sv
source/time_counter.sv
source/frame_buffer.sv
source/sck_divider.sv
source/ssd_spi_master.sv
source/timer_ssd_top.sv
dv/timer_ssd_assertions.sv
dv/timer_ssd_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the timer_ssd testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module timer_ssd_tb \
    -f timer_ssd.f

sim_out=$(./obj_dir/Vtimer_ssd_tb || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi
